// ==== include/pixel_cfg.svh ====
`ifndef PIXEL_CFG_SVH
`define PIXEL_CFG_SVH

// Block geometry
`define PIX_ROWS        4
`define PIX_KH_MAX      3

// Loop bounds
`define PIX_CI_MAX      4
`define PIX_XW_MAX      8
`define PIX_XH_MAX      16

// Stream word layout
`define PIX_WORD_BITS   8
`define PIX_S_WORDS     4

`define PIX_EDGE_WORDS  (`PIX_KH_MAX / 2)
`define PIX_RAM_DEPTH   (`PIX_CI_MAX * `PIX_XW_MAX)

`endif

// ==== logic/pixel_pkg.sv ====
`default_nettype none
`include "pixel_cfg.svh"

package pixel_pkg;

  // Field widths of the configuration word
  localparam int KH2_BITS = $clog2(`PIX_KH_MAX + 1);
  localparam int CI_BITS  = $clog2(`PIX_CI_MAX);
  localparam int XW_BITS  = $clog2(`PIX_XW_MAX);
  localparam int L_BITS   = $clog2(`PIX_XH_MAX / `PIX_ROWS);

  localparam int BEAT_BITS   = `PIX_S_WORDS * `PIX_WORD_BITS;
  localparam int CFG_PAD     = BEAT_BITS - KH2_BITS - CI_BITS - XW_BITS - L_BITS;
  localparam int GROUP_WORDS = `PIX_ROWS + `PIX_EDGE_WORDS;
  localparam int RAM_AW      = $clog2(`PIX_RAM_DEPTH);

  typedef logic [`PIX_WORD_BITS-1:0] pix_word_t;

  // Loop counts are stored minus one
  typedef struct packed {
    logic [CFG_PAD-1:0]  pad;
    logic [L_BITS-1:0]   l_last;
    logic [XW_BITS-1:0]  w_last;
    logic [CI_BITS-1:0]  ci_last;
    logic [KH2_BITS-1:0] kh2;
  } pix_cfg_t;

  // First beat of a frame is configuration, the rest are pixels
  typedef union packed {
    pix_word_t [`PIX_S_WORDS-1:0] pix;
    pix_cfg_t                     cfg;
  } s_beat_u;

  typedef pix_word_t [`PIX_ROWS-1:0] rows_t;

  // Column group from the gearbox, unused words are zero
  typedef struct packed {
    pix_word_t [GROUP_WORDS-1:0] words;
    logic                        last;
  } group_t;

endpackage

`default_nettype wire

// ==== logic/word_adapter.sv ====
`default_nettype none
`include "pixel_cfg.svh"

module word_adapter #(
  parameter int M_WORDS = `PIX_ROWS
) (
  input  wire logic                     aclk,
  input  wire logic                     aresetn,
  input  wire logic                     i_s_valid,
  input  wire logic                     i_s_last,
  input  wire pixel_pkg::s_beat_u       i_s_data,
  input  wire logic [`PIX_S_WORDS-1:0]  i_s_keep,
  output logic                          o_s_ready,
  output logic                          o_m_valid,
  output pixel_pkg::group_t             o_m_group,
  input  wire logic                     i_m_ready
);

  // Room for one partial group plus a full input beat
  localparam int BUF_WORDS = M_WORDS + `PIX_S_WORDS - 1;
  localparam int CNT_BITS  = $clog2(BUF_WORDS + 1);
  localparam logic [CNT_BITS-1:0] M_CNT = CNT_BITS'(M_WORDS);

  pixel_pkg::pix_word_t [BUF_WORDS-1:0] stage_q;
  pixel_pkg::pix_word_t [BUF_WORDS-1:0] stage_d;
  logic [CNT_BITS-1:0] count_q;
  logic [CNT_BITS-1:0] count_d;
  logic flush_q;
  logic flush_d;
  logic push;
  logic pop;
  logic group_last;

  // Stall input while a full group or the flush is pending
  assign o_s_ready  = (count_q < M_CNT) && !flush_q;
  assign o_m_valid  = (count_q >= M_CNT) || (flush_q && (count_q != '0));
  assign group_last = flush_q && (count_q <= M_CNT);

  assign push = i_s_valid && o_s_ready;
  assign pop  = o_m_valid && i_m_ready;

  always_comb begin
    stage_d = stage_q;
    count_d = count_q;
    flush_d = flush_q;
    if (pop) begin
      stage_d = stage_q >> (M_WORDS * `PIX_WORD_BITS);
      count_d = (count_q > M_CNT) ? count_q - M_CNT : '0;
      if (group_last) begin
        flush_d = 1'b0;
      end
    end else if (push) begin
      // Pack kept words in order behind the ones already staged
      for (int i = 0; i < `PIX_S_WORDS; i++) begin
        if (i_s_keep[i]) begin
          stage_d[count_d] = i_s_data.pix[i];
          count_d          = count_d + 1'b1;
        end
      end
      flush_d = i_s_last;
    end
  end

  always_comb begin
    o_m_group = '0;
    for (int i = 0; i < M_WORDS; i++) begin
      if (CNT_BITS'(i) < count_q) begin
        o_m_group.words[i] = stage_q[i];
      end
    end
    o_m_group.last = group_last;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count_q <= '0;
      flush_q <= 1'b0;
    end else begin
      count_q <= count_d;
      flush_q <= flush_d;
    end
  end

  always_ff @(posedge aclk) begin
    stage_q <= stage_d;
  end

endmodule

`default_nettype wire

// ==== logic/loop_counter.sv ====
`default_nettype none

module loop_counter #(
  parameter int W = 2
) (
  input  wire logic         aclk,
  input  wire logic         aresetn,
  input  wire logic         i_load,
  input  wire logic         i_en,
  input  wire logic [W-1:0] i_max,
  output logic [W-1:0]      o_count,
  output logic              o_first,
  output logic              o_last,
  output logic              o_last_clk
);

  assign o_first    = (o_count == '0);
  assign o_last     = (o_count == i_max);
  // Steps the next loop level out
  assign o_last_clk = i_en && o_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_count <= '0;
    end else if (i_load) begin
      o_count <= '0;
    end else if (i_en) begin
      o_count <= o_last ? '0 : o_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/edge_ram.sv ====
`default_nettype none
`include "pixel_cfg.svh"

module edge_ram (
  input  wire logic                                        aclk,
  input  wire logic                                        i_en,
  input  wire logic                                        i_we,
  input  wire logic [pixel_pkg::RAM_AW-1:0]                i_addr,
  input  wire pixel_pkg::pix_word_t [`PIX_EDGE_WORDS-1:0]  i_din,
  output pixel_pkg::pix_word_t [`PIX_EDGE_WORDS-1:0]       o_dout
);

  // One entry of bottom rows per (w, ci) column
  pixel_pkg::pix_word_t [`PIX_EDGE_WORDS-1:0] mem [`PIX_RAM_DEPTH];

  // Read first, so a write replaces the output word
  always_ff @(posedge aclk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_din;
      end
      o_dout <= mem[i_addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/pixel_shifter.sv ====
`default_nettype none
`include "pixel_cfg.svh"

module pixel_shifter (
  input  wire logic                     aclk,
  input  wire logic                     aresetn,
  output logic                          o_s_ready,
  input  wire logic                     i_s_valid,
  input  wire logic                     i_s_last,
  input  wire pixel_pkg::s_beat_u       i_s_data,
  input  wire logic [`PIX_S_WORDS-1:0]  i_s_keep,
  input  wire logic                     i_m_ready,
  output logic                          o_m_valid,
  output logic                          o_m_last,
  output pixel_pkg::rows_t              o_m_data
);

  localparam int ROWS        = `PIX_ROWS;
  localparam int EDGE        = `PIX_EDGE_WORDS;
  localparam int SHIFT_WORDS = ROWS + 2 * EDGE;
  localparam int KH_BITS     = $clog2(2 * EDGE + 1);

  typedef enum logic [1:0] {SET, PASS, BLOCK} state_t;

  state_t state_q;
  pixel_pkg::pix_cfg_t cfg_q;
  pixel_pkg::pix_cfg_t cfg_in;
  logic use_rows;
  logic cfg_beat;
  logic s_last_beat;
  logic m_last_beat;

  logic ro_s_valid, ro_s_ready, ro_m_valid, ro_m_ready;
  logic re_s_valid, re_s_ready, re_m_valid, re_m_ready;
  pixel_pkg::group_t ro_group;
  pixel_pkg::group_t re_group;
  pixel_pkg::group_t grp;
  logic grp_valid;

  logic en_shift, en_kh, en_copy, load_cnt;
  logic [KH_BITS-1:0] kh_max;
  logic last_kh, last_clk_kh;
  logic [pixel_pkg::CI_BITS-1:0] ci_cnt;
  logic [pixel_pkg::XW_BITS-1:0] w_cnt;
  logic last_clk_ci, last_clk_w, first_l, last_l;

  logic [pixel_pkg::RAM_AW-1:0] ram_addr, ram_addr_r, ram_addr_in;
  logic ram_ren, ram_wen, ram_ren_q;
  pixel_pkg::pix_word_t [EDGE-1:0] ram_dout, ram_hold_q, ram_dout_r;
  pixel_pkg::pix_word_t [EDGE-1:0] edge_top, edge_bot;

  logic copy_r, last_kh_r, last_clk_kh_r, grp_last_r, first_l_r, last_l_r;
  pixel_pkg::pix_word_t [pixel_pkg::GROUP_WORDS-1:0] grp_words_r;
  pixel_pkg::pix_word_t [SHIFT_WORDS-1:0] shift_q;
  logic m_last_q;

  assign cfg_beat    = (state_q == SET) && i_s_valid;
  assign s_last_beat = i_s_valid && o_s_ready && i_s_last;
  assign m_last_beat = o_m_valid && i_m_ready && o_m_last;
  assign use_rows    = (cfg_q.kh2 == '0);

  always_comb begin
    cfg_in = i_s_data.cfg;
    if (cfg_in.kh2 > pixel_pkg::KH2_BITS'(EDGE)) begin
      cfg_in.kh2 = '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= SET;
      cfg_q   <= '0;
    end else begin
      if (cfg_beat) begin
        cfg_q <= cfg_in;
      end
      case (state_q)
        SET:     if (cfg_beat) state_q <= PASS;
        PASS:    if (s_last_beat) state_q <= BLOCK;
        BLOCK:   if (m_last_beat) state_q <= SET;
        default: state_q <= SET;
      endcase
    end
  end

  // Input steering, only the selected gearbox sees the stream
  always_comb begin
    ro_s_valid = 1'b0;
    re_s_valid = 1'b0;
    case (state_q)
      SET: o_s_ready = 1'b1;
      PASS: begin
        o_s_ready  = use_rows ? ro_s_ready : re_s_ready;
        ro_s_valid = use_rows && i_s_valid;
        re_s_valid = !use_rows && i_s_valid;
      end
      default: o_s_ready = 1'b0;
    endcase
  end

  word_adapter #(
    .M_WORDS (ROWS)
  ) u_dw_rows (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (ro_s_valid),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_s_ready (ro_s_ready),
    .o_m_valid (ro_m_valid),
    .o_m_group (ro_group),
    .i_m_ready (ro_m_ready)
  );

  word_adapter #(
    .M_WORDS (pixel_pkg::GROUP_WORDS)
  ) u_dw_edges (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (re_s_valid),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .o_s_ready (re_s_ready),
    .o_m_valid (re_m_valid),
    .o_m_group (re_group),
    .i_m_ready (re_m_ready)
  );

  assign grp_valid  = use_rows ? ro_m_valid : re_m_valid;
  assign grp        = use_rows ? ro_group : re_group;
  assign ro_m_ready = use_rows && en_copy;
  assign re_m_ready = !use_rows && en_copy;

  // Kernel steps freely, waits at its last step for a group or the tail
  assign load_cnt = (state_q == SET);
  assign en_shift = (state_q != SET) && i_m_ready;
  assign en_kh    = en_shift && (!last_kh || grp_valid || m_last_q || grp_last_r);
  assign en_copy  = grp_valid && last_clk_kh;
  assign kh_max   = KH_BITS'(2 * cfg_q.kh2);

  loop_counter #(.W(KH_BITS)) u_cnt_kh (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_load     (load_cnt),
    .i_en       (en_kh),
    .i_max      (kh_max),
    .o_count    (),
    .o_first    (),
    .o_last     (last_kh),
    .o_last_clk (last_clk_kh)
  );

  loop_counter #(.W(pixel_pkg::CI_BITS)) u_cnt_ci (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_load     (load_cnt),
    .i_en       (last_clk_kh),
    .i_max      (cfg_q.ci_last),
    .o_count    (ci_cnt),
    .o_first    (),
    .o_last     (),
    .o_last_clk (last_clk_ci)
  );

  loop_counter #(.W(pixel_pkg::XW_BITS)) u_cnt_w (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_load     (load_cnt),
    .i_en       (last_clk_ci),
    .i_max      (cfg_q.w_last),
    .o_count    (w_cnt),
    .o_first    (),
    .o_last     (),
    .o_last_clk (last_clk_w)
  );

  loop_counter #(.W(pixel_pkg::L_BITS)) u_cnt_l (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_load     (load_cnt),
    .i_en       (last_clk_w),
    .i_max      (cfg_q.l_last),
    .o_count    (),
    .o_first    (first_l),
    .o_last     (last_l),
    .o_last_clk ()
  );

  // Halo stage, one cycle behind the copy to match the RAM read
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      copy_r        <= 1'b0;
      last_kh_r     <= 1'b0;
      last_clk_kh_r <= 1'b0;
      grp_last_r    <= 1'b0;
      first_l_r     <= 1'b0;
      last_l_r      <= 1'b0;
    end else if (en_shift) begin
      copy_r        <= en_copy;
      last_kh_r     <= last_kh;
      last_clk_kh_r <= last_clk_kh;
      grp_last_r    <= grp_valid && grp.last;
      first_l_r     <= first_l;
      last_l_r      <= last_l;
    end
  end

  always_ff @(posedge aclk) begin
    if (en_shift) begin
      grp_words_r <= grp.words;
      ram_addr_r  <= ram_addr;
    end
  end

  assign ram_addr    = pixel_pkg::RAM_AW'(w_cnt * `PIX_CI_MAX + ci_cnt);
  assign ram_ren     = en_copy && !first_l;
  assign ram_wen     = copy_r && !last_l_r && en_shift;
  assign ram_addr_in = ram_wen ? ram_addr_r : ram_addr;
  assign edge_bot    = grp_words_r[ROWS-1 -: EDGE];

  edge_ram u_edge_ram (
    .aclk   (aclk),
    .i_en   (ram_ren || ram_wen),
    .i_we   (ram_wen),
    .i_addr (ram_addr_in),
    .i_din  (edge_bot),
    .o_dout (ram_dout)
  );

  // Keep the read word once a stall or a later write moves the RAM output
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ram_ren_q <= 1'b0;
    end else begin
      ram_ren_q <= ram_ren;
    end
  end

  always_ff @(posedge aclk) begin
    if (ram_ren_q) begin
      ram_hold_q <= ram_dout;
    end
  end

  assign ram_dout_r = ram_ren_q ? ram_dout : ram_hold_q;
  assign edge_top   = first_l_r ? '0 : ram_dout_r;

  // Top halo in the low words, one row down per kernel step
  always_ff @(posedge aclk) begin
    if (en_shift) begin
      if (copy_r) begin
        shift_q <= {grp_words_r, edge_top};
      end else begin
        shift_q <= shift_q >> `PIX_WORD_BITS;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      o_m_data[r] = shift_q[r + EDGE - int'(cfg_q.kh2)];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_m_valid <= 1'b0;
      m_last_q  <= 1'b0;
    end else if (m_last_beat) begin
      o_m_valid <= 1'b0;
      m_last_q  <= 1'b0;
    end else if (en_shift) begin
      if (copy_r) begin
        m_last_q <= grp_last_r;
      end
      // Valid is decided once per group, at the kernel wrap
      if (last_kh_r) begin
        o_m_valid <= copy_r;
      end
    end
  end

  assign o_m_last = m_last_q && last_clk_kh_r;

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic o_aclk,
  output logic o_aresetn
);

  initial begin
    o_aclk = 1'b0;
    forever #50 o_aclk = ~o_aclk;
  end

  // Reset held low for eight clocks, released on a falling edge
  initial begin
    o_aresetn = 1'b0;
    repeat (8) @(posedge o_aclk);
    @(negedge o_aclk);
    o_aresetn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/pixel_shifter_tb.sv ====
`default_nettype none
`include "pixel_cfg.svh"

module pixel_shifter_tb;

  localparam int ROWS     = `PIX_ROWS;
  localparam int EDGE     = `PIX_EDGE_WORDS;
  localparam int NFRAMES  = 6;
  localparam int BEAT_W   = pixel_pkg::BEAT_BITS;

  typedef struct packed {
    logic [pixel_pkg::KH2_BITS-1:0] kh2;
    logic [pixel_pkg::CI_BITS-1:0]  ci_last;
    logic [pixel_pkg::XW_BITS-1:0]  w_last;
    logic [pixel_pkg::L_BITS-1:0]   l_last;
    logic                           stall;
    logic                           keep_mix;
  } frame_t;

  logic aclk;
  logic aresetn;
  logic s_valid;
  logic s_last;
  logic s_ready;
  pixel_pkg::s_beat_u s_data;
  logic [`PIX_S_WORDS-1:0] s_keep;
  logic m_ready;
  logic m_valid;
  logic m_last;
  pixel_pkg::rows_t m_data;

  frame_t frames [NFRAMES];
  logic [BEAT_W-1:0] in_data [$];
  logic [`PIX_S_WORDS-1:0] in_keep [$];
  logic in_last [$];
  int in_frame [$];
  pixel_pkg::rows_t exp_data [$];
  logic exp_last [$];
  int exp_base [NFRAMES];
  int exp_count [NFRAMES];

  integer seed = 15;
  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int limit = 0;

  tb_clock_gen u_clk (
    .o_aclk    (aclk),
    .o_aresetn (aresetn)
  );

  pixel_shifter u_dut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .o_s_ready (s_ready),
    .i_s_valid (s_valid),
    .i_s_last  (s_last),
    .i_s_data  (s_data),
    .i_s_keep  (s_keep),
    .i_m_ready (m_ready),
    .o_m_valid (m_valid),
    .o_m_last  (m_last),
    .o_m_data  (m_data)
  );

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // kh2, ci_last, w_last, l_last, stall, keep mix
  task automatic load_table();
    frames[0] = '{2'd0, 2'd1, 3'd1, 2'd1, 1'b0, 1'b0};
    frames[1] = '{2'd1, 2'd1, 3'd2, 2'd2, 1'b0, 1'b0};
    frames[2] = '{2'd1, 2'd2, 3'd1, 2'd2, 1'b1, 1'b1};
    frames[3] = '{2'd0, 2'd0, 3'd2, 2'd1, 1'b1, 1'b1};
    frames[4] = '{2'd2, 2'd1, 3'd0, 2'd1, 1'b1, 1'b0};
    frames[5] = '{2'd1, 2'd0, 3'd0, 2'd3, 1'b1, 1'b1};
  endtask

  // Input beats and expected windows for one frame
  task automatic build_frame(input int f);
    int eff, gw, nci, nw, ngroups, total, pos, g, gp, nbeats;
    pixel_pkg::pix_word_t words [$];
    pixel_pkg::pix_word_t col [ROWS + 2 * EDGE];
    pixel_pkg::pix_cfg_t cfg;
    pixel_pkg::s_beat_u beat;
    pixel_pkg::rows_t row;
    logic [`PIX_S_WORDS-1:0] keep;
    eff = (int'(frames[f].kh2) > EDGE) ? 0 : int'(frames[f].kh2);
    gw = (eff == 0) ? ROWS : ROWS + EDGE;
    nci = int'(frames[f].ci_last) + 1;
    nw = int'(frames[f].w_last) + 1;
    ngroups = (int'(frames[f].l_last) + 1) * nw * nci;
    total = ngroups * gw;
    for (int i = 0; i < total; i++) begin
      words.push_back(pixel_pkg::pix_word_t'($random(seed)));
    end
    cfg = '0;
    cfg.kh2 = frames[f].kh2;
    cfg.ci_last = frames[f].ci_last;
    cfg.w_last = frames[f].w_last;
    cfg.l_last = frames[f].l_last;
    beat.cfg = cfg;
    in_data.push_back(beat);
    in_keep.push_back('1);
    in_last.push_back(1'b0);
    in_frame.push_back(f);
    nbeats = 1;
    pos = 0;
    while (pos < total) begin
      keep = frames[f].keep_mix ? `PIX_S_WORDS'($random(seed)) : '1;
      if (keep == '0) begin
        keep = 1;
      end
      for (int lane = 0; lane < `PIX_S_WORDS; lane++) begin
        if (keep[lane] && pos < total) begin
          beat.pix[lane] = words[pos];
          pos++;
        end else begin
          // Dropped lanes carry junk that must not reach the output
          keep[lane] = 1'b0;
          beat.pix[lane] = pixel_pkg::pix_word_t'($random(seed));
        end
      end
      in_data.push_back(beat);
      in_keep.push_back(keep);
      in_last.push_back(pos == total);
      in_frame.push_back(f);
      nbeats++;
    end
    exp_base[f] = exp_data.size();
    for (int l = 0; l <= int'(frames[f].l_last); l++) begin
      for (int w = 0; w < nw; w++) begin
        for (int ci = 0; ci < nci; ci++) begin
          g = (l * nw + w) * nci + ci;
          foreach (col[k]) col[k] = '0;
          if (l > 0) begin
            gp = ((l - 1) * nw + w) * nci + ci;
            col[0] = words[gp * gw + ROWS - 1];
          end
          for (int k = 0; k < gw; k++) begin
            col[EDGE + k] = words[g * gw + k];
          end
          for (int j = 0; j <= 2 * eff; j++) begin
            for (int r = 0; r < ROWS; r++) begin
              row[r] = col[r + EDGE - eff + j];
            end
            exp_data.push_back(row);
            exp_last.push_back((g == ngroups - 1) && (j == 2 * eff));
          end
        end
      end
    end
    exp_count[f] = exp_data.size() - exp_base[f];
    limit += (nbeats + exp_count[f]) * 4;
  endtask

  task automatic drive_input();
    for (int i = 0; i < in_data.size(); i++) begin
      @(negedge aclk);
      while (frames[in_frame[i]].stall && (($random(seed) & 3) == 0)) begin
        s_valid = 1'b0;
        @(negedge aclk);
      end
      s_valid = 1'b1;
      s_data = in_data[i];
      s_keep = in_keep[i];
      s_last = in_last[i];
      #1;
      while (!s_ready) begin
        @(negedge aclk);
        #1;
      end
    end
    @(negedge aclk);
    s_valid = 1'b0;
    s_last = 1'b0;
  endtask

  task automatic collect_output();
    int got;
    int frame_errors;
    logic done;
    for (int f = 0; f < NFRAMES; f++) begin
      got = 0;
      done = 1'b0;
      frame_errors = errors;
      while (!done) begin
        @(negedge aclk);
        m_ready = frames[f].stall ? (($random(seed) & 3) != 0) : 1'b1;
        #1;
        if (m_valid && m_ready) begin
          if (got < exp_count[f]) begin
            check_value($sformatf("frame %0d beat %0d data", f, got), 64'(m_data),
                        64'(exp_data[exp_base[f] + got]));
            check_value($sformatf("frame %0d beat %0d last", f, got), 64'(m_last),
                        64'(exp_last[exp_base[f] + got]));
          end
          got++;
          done = m_last;
        end
      end
      check_value($sformatf("frame %0d beat count", f), 64'(got), 64'(exp_count[f]));
      $display("frame %0d kh2 %0d beats %0d errors %0d", f, frames[f].kh2, got,
               errors - frame_errors);
    end
    m_ready = 1'b1;
  endtask

  always @(posedge aclk) begin
    if (aresetn) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
        $display("Run hung: frames not finished after %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
      end
    end
  end

  initial begin
    s_valid = 1'b0;
    s_last = 1'b0;
    s_data = '0;
    s_keep = '0;
    m_ready = 1'b0;
    load_table();
    for (int f = 0; f < NFRAMES; f++) begin
      build_frame(f);
    end
    limit += 200;
    @(posedge aresetn);
    @(negedge aclk);
    check_value("reset o_m_valid", 64'(m_valid), 64'd0);
    check_value("reset o_m_last", 64'(m_last), 64'd0);
    check_value("reset o_s_ready", 64'(s_ready), 64'd1);
    fork
      drive_input();
      collect_output();
    join
    $display("frames %0d checks %0d errors %0d", NFRAMES, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
logic/pixel_pkg.sv
logic/word_adapter.sv
logic/loop_counter.sv
logic/edge_ram.sv
logic/pixel_shifter.sv
verif/tb_clock_gen.sv
verif/pixel_shifter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := pixel_shifter_tb
FILELIST  := filelist.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) include/pixel_cfg.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
